//--- hdl/core_isa_pkg.sv
`default_nettype none

package core_isa_pkg;

  localparam int WORD_W   = 32;
  localparam int NUM_REGS = 32;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [31:0]       inst_t;
  typedef logic [4:0]        reg_num_t;
  typedef logic [3:0]        opcode_t;
  typedef logic [2:0]        alu_op_t;

  // Instruction fields
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 28;
  localparam int RD_MSB  = 27;
  localparam int RD_LSB  = 23;
  localparam int RS_MSB  = 22;
  localparam int RS_LSB  = 18;
  localparam int RT_MSB  = 17;
  localparam int RT_LSB  = 13;
  localparam int IMM_MSB = 12;
  localparam int IMM_LSB = 0;
  localparam int IMM_W   = IMM_MSB - IMM_LSB + 1; // Signed immediate

  localparam opcode_t OP_NOP  = 4'd0;
  localparam opcode_t OP_ADD  = 4'd1;
  localparam opcode_t OP_SUB  = 4'd2;
  localparam opcode_t OP_AND  = 4'd3;
  localparam opcode_t OP_OR   = 4'd4;
  localparam opcode_t OP_XOR  = 4'd5;
  localparam opcode_t OP_SHL  = 4'd6; // rs << rt[4:0]
  localparam opcode_t OP_ADDI = 4'd7; // rs + sext(imm)

  // ALU function select
  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  localparam alu_op_t ALU_SHL = 3'd5;

endpackage

`default_nettype wire

//--- hdl/core_pipe_pkg.sv
`default_nettype none

package core_pipe_pkg;

  localparam int NUM_LANES   = 4;
  localparam int QUEUE_DEPTH = 4; // In packets

  // Queue pointer and credit counter widths
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CREDIT_W    = $clog2(QUEUE_DEPTH + 1);

  // Lane 0 sits in the low 32 bits
  typedef core_isa_pkg::inst_t [NUM_LANES-1:0] packet_t;

  typedef logic [CREDIT_W-1:0]  credit_cnt_t;
  typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

//--- hdl/packet_queue.sv
`timescale 1ns/10ps
`default_nettype none

module packet_queue
  import core_pipe_pkg::*;
(
  input  wire logic    clkrst_core_clk,
  input  wire logic    clkrst_core_rst_n,
  input  wire logic    in_valid,
  input  wire packet_t in_packet,
  input  wire logic    q_pop,
  output logic         q_valid,
  output packet_t      q_packet,
  output logic         credit_return
);

  packet_t                buf_mem [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  credit_cnt_t            count;   // Occupancy
  logic                   pop;

  assign q_valid       = (count != '0);
  assign q_packet      = buf_mem[rd_ptr];
  assign pop           = q_pop & q_valid;
  assign credit_return = pop;      // One credit back per packet leaving

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({in_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Idle or push and pop together
      endcase
    end
  end

  // Source never sends without a credit, so no full check
  always_ff @(posedge clkrst_core_clk) begin
    if (in_valid) begin
      buf_mem[wr_ptr] <= in_packet;
    end
  end

endmodule

`default_nettype wire

//--- hdl/issue_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module issue_ctrl
  import core_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  wire logic                     clkrst_core_clk,
  input  wire logic                     clkrst_core_rst_n,
  input  wire logic                     q_valid,
  input  wire packet_t                  q_packet,
  input  wire reg_num_t [NUM_LANES-1:0] rs_num,
  input  wire reg_num_t [NUM_LANES-1:0] rt_num,
  input  wire reg_num_t [NUM_LANES-1:0] rd_num,
  input  wire lane_mask_t               rd_we,
  input  wire alu_op_t [NUM_LANES-1:0]  alu_op,
  input  wire word_t [NUM_LANES-1:0]    imm,
  input  wire lane_mask_t               use_imm,
  input  wire word_t [NUM_LANES-1:0]    rs_data,
  input  wire word_t [NUM_LANES-1:0]    rt_data,
  input  wire logic                     wb_valid,
  input  wire lane_mask_t               wb_we,
  input  wire reg_num_t [NUM_LANES-1:0] wb_rd_num,
  output logic                          q_pop,
  output packet_t                       dcd_packet,
  output reg_num_t [NUM_LANES-1:0]      rf_rs_num,
  output reg_num_t [NUM_LANES-1:0]      rf_rt_num,
  output logic                          ex_valid,
  output word_t [NUM_LANES-1:0]         ex_op_a,
  output word_t [NUM_LANES-1:0]         ex_op_b,
  output alu_op_t [NUM_LANES-1:0]       ex_alu_op,
  output reg_num_t [NUM_LANES-1:0]      ex_rd_num,
  output lane_mask_t                    ex_rd_we
);

  logic                   dcd_valid;
  logic [NUM_REGS-1:0]    sb;          // Pending writes, one bit per register
  logic [NUM_REGS-1:0]    sb_set;
  logic [NUM_REGS-1:0]    sb_clr;
  lane_mask_t             lane_stall;
  logic                   issue;
  word_t [NUM_LANES-1:0]  op_a;
  word_t [NUM_LANES-1:0]  op_b;

  assign rf_rs_num = rs_num;
  assign rf_rt_num = rt_num;

  // RAW on sources, WAW on destination; lanes that write nothing never stall
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_stall[i] = rd_we[i] & (sb[rs_num[i]] | (~use_imm[i] & sb[rt_num[i]]) |
                                  sb[rd_num[i]]);
    end
  end

  assign issue = dcd_valid & ~(|lane_stall); // Execute never blocks
  assign q_pop = q_valid & (~dcd_valid | issue);

  always_comb begin
    sb_set = '0;
    sb_clr = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (issue && rd_we[i]) sb_set[rd_num[i]] = 1'b1;
      if (wb_valid && wb_we[i]) sb_clr[wb_rd_num[i]] = 1'b1;
    end
  end

  // Register 0 always reads as zero
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      op_a[i] = (rs_num[i] == '0) ? '0 : rs_data[i];
      if (use_imm[i]) op_b[i] = imm[i];
      else            op_b[i] = (rt_num[i] == '0) ? '0 : rt_data[i];
    end
  end

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      dcd_valid <= 1'b0;
      ex_valid  <= 1'b0;
      ex_rd_we  <= '0;
      sb        <= '0;
    end else begin
      if (q_pop)      dcd_valid <= 1'b1;
      else if (issue) dcd_valid <= 1'b0;
      ex_valid <= issue;
      ex_rd_we <= issue ? rd_we : '0;
      sb       <= (sb & ~sb_clr) | sb_set;
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (q_pop) dcd_packet <= q_packet;
    if (issue) begin
      ex_op_a   <= op_a;
      ex_op_b   <= op_b;
      ex_alu_op <= alu_op;
      ex_rd_num <= rd_num;
    end
  end

endmodule

`default_nettype wire

//--- hdl/lane_decode.sv
`timescale 1ns/10ps
`default_nettype none

module lane_decode
  import core_isa_pkg::*;
(
  input  wire inst_t inst,
  output reg_num_t   rs_num,
  output reg_num_t   rt_num,
  output reg_num_t   rd_num,
  output logic       rd_we,
  output alu_op_t    alu_op,
  output word_t      imm,
  output logic       use_imm
);

  opcode_t opcode;
  logic    valid_op;

  assign opcode = inst[OPC_MSB:OPC_LSB];
  assign rd_num = inst[RD_MSB:RD_LSB];
  assign rs_num = inst[RS_MSB:RS_LSB];
  assign rt_num = inst[RT_MSB:RT_LSB];
  assign imm    = {{(WORD_W - IMM_W){inst[IMM_MSB]}}, inst[IMM_MSB:IMM_LSB]}; // Sign extend

  always_comb begin
    valid_op = 1'b1;
    alu_op   = ALU_ADD;
    use_imm  = 1'b0;
    case (opcode)
      OP_ADD: alu_op = ALU_ADD;
      OP_SUB: alu_op = ALU_SUB;
      OP_AND: alu_op = ALU_AND;
      OP_OR:  alu_op = ALU_OR;
      OP_XOR: alu_op = ALU_XOR;
      OP_SHL: alu_op = ALU_SHL;
      OP_ADDI: begin
        alu_op  = ALU_ADD;
        use_imm = 1'b1;
      end
      default: valid_op = 1'b0;  // OP_NOP and undefined codes
    endcase
  end

  // Writes to r0 are dropped here so r0 never enters the scoreboard
  assign rd_we = valid_op & (rd_num != '0);

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
  import core_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  wire logic                     clkrst_core_clk,
  input  wire logic                     clkrst_core_rst_n,
  input  wire reg_num_t [NUM_LANES-1:0] rs_num,
  input  wire reg_num_t [NUM_LANES-1:0] rt_num,
  output word_t [NUM_LANES-1:0]         rs_data,
  output word_t [NUM_LANES-1:0]         rt_data,
  input  wire lane_mask_t               wr_we,
  input  wire reg_num_t [NUM_LANES-1:0] wr_num,
  input  wire word_t [NUM_LANES-1:0]    wr_data
);

  word_t regs [1:NUM_REGS-1];  // r0 is not stored

  // Plain combinational reads; the scoreboard keeps them hazard free
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rs_data[i] = regs[rs_num[i]];
      rt_data[i] = regs[rt_num[i]];
    end
  end

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      for (int r = 1; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // Ascending lane order, so the highest lane's write lands last
      for (int i = 0; i < NUM_LANES; i++) begin
        if (wr_we[i] && wr_num[i] != '0) begin
          regs[wr_num[i]] <= wr_data[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/lane_alu.sv
`timescale 1ns/10ps
`default_nettype none

module lane_alu
  import core_isa_pkg::*;
(
  input  wire word_t   op_a,
  input  wire word_t   op_b,
  input  wire alu_op_t alu_op,
  output word_t        result
);

  logic [4:0] shamt;

  assign shamt = op_b[4:0];  // Only the low 5 bits shift

  always_comb begin
    case (alu_op)
      ALU_ADD: result = op_a + op_b;  // Also ADDI
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_XOR: result = op_a ^ op_b;
      ALU_SHL: result = op_a << shamt;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/mcpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_core
  import core_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  wire logic                clkrst_core_clk,
  input  wire logic                clkrst_core_rst_n,
  input  wire logic                in_valid,
  input  wire packet_t             in_packet,
  output logic                     credit_return,
  output logic                     wb_valid,
  output lane_mask_t               wb_we,
  output reg_num_t [NUM_LANES-1:0] wb_rd_num,
  output word_t [NUM_LANES-1:0]    wb_rd_data
);

  logic                     q_valid;
  packet_t                  q_packet;
  logic                     q_pop;
  packet_t                  dcd_packet;
  reg_num_t [NUM_LANES-1:0] dec_rs_num;
  reg_num_t [NUM_LANES-1:0] dec_rt_num;
  reg_num_t [NUM_LANES-1:0] dec_rd_num;
  lane_mask_t               dec_rd_we;
  alu_op_t [NUM_LANES-1:0]  dec_alu_op;
  word_t [NUM_LANES-1:0]    dec_imm;
  lane_mask_t               dec_use_imm;
  reg_num_t [NUM_LANES-1:0] rf_rs_num;
  reg_num_t [NUM_LANES-1:0] rf_rt_num;
  word_t [NUM_LANES-1:0]    rs_data;
  word_t [NUM_LANES-1:0]    rt_data;
  logic                     ex_valid;
  word_t [NUM_LANES-1:0]    ex_op_a;
  word_t [NUM_LANES-1:0]    ex_op_b;
  alu_op_t [NUM_LANES-1:0]  ex_alu_op;
  reg_num_t [NUM_LANES-1:0] ex_rd_num;
  lane_mask_t               ex_rd_we;
  word_t [NUM_LANES-1:0]    alu_result;

  packet_queue packet_queue_inst (
    .clkrst_core_clk, .clkrst_core_rst_n,
    .in_valid, .in_packet, .q_pop,
    .q_valid, .q_packet, .credit_return
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    lane_decode lane_decode_inst (
      .inst    (dcd_packet[i]),
      .rs_num  (dec_rs_num[i]),
      .rt_num  (dec_rt_num[i]),
      .rd_num  (dec_rd_num[i]),
      .rd_we   (dec_rd_we[i]),
      .alu_op  (dec_alu_op[i]),
      .imm     (dec_imm[i]),
      .use_imm (dec_use_imm[i])
    );

    lane_alu lane_alu_inst (
      .op_a   (ex_op_a[i]),
      .op_b   (ex_op_b[i]),
      .alu_op (ex_alu_op[i]),
      .result (alu_result[i])
    );
  end

  issue_ctrl issue_ctrl_inst (
    .clkrst_core_clk, .clkrst_core_rst_n,
    .q_valid, .q_packet,
    .rs_num (dec_rs_num), .rt_num (dec_rt_num), .rd_num (dec_rd_num),
    .rd_we  (dec_rd_we),  .alu_op (dec_alu_op), .imm    (dec_imm),
    .use_imm (dec_use_imm),
    .rs_data, .rt_data,
    .wb_valid, .wb_we, .wb_rd_num,
    .q_pop, .dcd_packet, .rf_rs_num, .rf_rt_num,
    .ex_valid, .ex_op_a, .ex_op_b, .ex_alu_op, .ex_rd_num, .ex_rd_we
  );

  reg_file reg_file_inst (
    .clkrst_core_clk, .clkrst_core_rst_n,
    .rs_num (rf_rs_num), .rt_num (rf_rt_num),
    .rs_data, .rt_data,
    .wr_we (wb_we), .wr_num (wb_rd_num), .wr_data (wb_rd_data)
  );

  // Writeback register, always accepts
  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      wb_valid <= 1'b0;
      wb_we    <= '0;
    end else begin
      wb_valid <= ex_valid;
      wb_we    <= ex_rd_we;   // Already zero on empty execute slots
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (ex_valid) begin
      wb_rd_num  <= ex_rd_num;
      wb_rd_data <= alu_result;
    end
  end

endmodule

`default_nettype wire

//--- test/mcpu_core_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_core_asserts
  import core_pipe_pkg::*;
(
  input wire logic        clkrst_core_clk,
  input wire logic        clkrst_core_rst_n,
  input wire logic        credit_return,
  input wire logic        wb_valid,
  input wire lane_mask_t  wb_we,
  input wire credit_cnt_t q_count,
  input wire logic        issue
);

  // Source keeps to its credits, so the buffer never overflows
  a_queue_bound: assert property (
    @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
    q_count <= QUEUE_DEPTH)
    else $error("Packet queue holds %0d packets, above its depth", q_count);

  a_we_idle: assert property (
    @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
    !wb_valid |-> (wb_we == '0))
    else $error("wb_we is %b while wb_valid is low", wb_we);

  // One cycle in execute, one into the writeback register
  a_issue_to_wb: assert property (
    @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
    wb_valid == $past(issue, 2))
    else $error("wb_valid does not follow issue by exactly two cycles");

  a_reset_quiet: assert property (
    @(posedge clkrst_core_clk)
    $rose(clkrst_core_rst_n) |-> (!credit_return && !wb_valid))
    else $error("credit_return or wb_valid active right after reset release");

endmodule

`default_nettype wire

//--- test/mcpu_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_core_tb
  import core_isa_pkg::*;
  import core_pipe_pkg::*;
();

  localparam int WAIT_LIMIT = 500;  // Cycles per wait loop

  logic                     clkrst_core_clk;
  logic                     clkrst_core_rst_n;
  logic                     in_valid;
  packet_t                  in_packet;
  logic                     credit_return;
  logic                     wb_valid;
  lane_mask_t               wb_we;
  reg_num_t [NUM_LANES-1:0] wb_rd_num;
  word_t [NUM_LANES-1:0]    wb_rd_data;

  word_t                    ref_regs [NUM_REGS];  // Reference register state
  lane_mask_t               exp_we_q [$];
  reg_num_t [NUM_LANES-1:0] exp_num_q [$];
  word_t [NUM_LANES-1:0]    exp_data_q [$];
  logic [31:0]              lcg_state;
  string                    test_name;
  int sent_cnt = 0;
  int ret_cnt = 0;
  int wb_cnt = 0;
  int err_cnt = 0;
  int test_errs = 0;
  int test_cnt = 0;
  int fail_cnt = 0;
  int min_credits = QUEUE_DEPTH;
  bit timed_out = 1'b0;

  mcpu_core mcpu_core_inst (.*);

  bind mcpu_core mcpu_core_asserts mcpu_core_asserts_inst (
    .clkrst_core_clk, .clkrst_core_rst_n, .credit_return, .wb_valid, .wb_we,
    .q_count (packet_queue_inst.count),
    .issue   (issue_ctrl_inst.issue)
  );

  initial begin
    clkrst_core_clk = 1'b0;
    forever #2 clkrst_core_clk = ~clkrst_core_clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int credits();
    return QUEUE_DEPTH - sent_cnt + ret_cnt;
  endfunction

  function automatic inst_t make_inst(logic [3:0] op, logic [4:0] rd, logic [4:0] rs,
                                      logic [4:0] rt, logic [12:0] imm);
    return {op, rd, rs, rt, imm};
  endfunction

  // Register fields limited to 0..span-1 to steer the hazard rate
  function automatic packet_t random_packet(input int span);
    packet_t     pkt;
    logic [31:0] r;
    logic [31:0] s;
    for (int i = 0; i < NUM_LANES; i++) begin
      r = next_random();
      s = next_random();
      pkt[i] = make_inst(r[31:28], 5'(r[27:23] % span), 5'(r[22:18] % span),
                         5'(r[17:13] % span), s[31:19]);
    end
    return pkt;
  endfunction

  // All lanes read the state before the packet, then write in lane order
  task automatic expect_packet(input packet_t pkt);
    lane_mask_t               we;
    reg_num_t [NUM_LANES-1:0] nums;
    word_t [NUM_LANES-1:0]    data;
    word_t                    a;
    word_t                    b;
    logic [3:0]               op;
    for (int i = 0; i < NUM_LANES; i++) begin
      op      = pkt[i][31:28];
      nums[i] = pkt[i][27:23];
      a       = ref_regs[pkt[i][22:18]];
      b       = (op == 4'd7) ? {{19{pkt[i][12]}}, pkt[i][12:0]} : ref_regs[pkt[i][17:13]];
      case (op)
        4'd1, 4'd7: data[i] = a + b;
        4'd2:       data[i] = a - b;
        4'd3:       data[i] = a & b;
        4'd4:       data[i] = a | b;
        4'd5:       data[i] = a ^ b;
        4'd6:       data[i] = a << b[4:0];
        default:    data[i] = '0;
      endcase
      we[i] = (op >= 4'd1) && (op <= 4'd7) && (nums[i] != 5'd0);
    end
    for (int i = 0; i < NUM_LANES; i++) begin
      if (we[i]) ref_regs[nums[i]] = data[i];
    end
    exp_we_q.push_back(we);
    exp_num_q.push_back(nums);
    exp_data_q.push_back(data);
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout in %s: %s", test_name, what);
    timed_out = 1'b1;
    forever @(posedge clkrst_core_clk);  // Park here until the run ends
  endtask

  task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("** Error %s: %s expected %h, got %h", test_name, what, exp, act);
    err_cnt++;
  endtask

  task automatic send_packet(input packet_t pkt);
    int waited;
    waited = 0;
    while (credits() == 0) begin
      if (waited == WAIT_LIMIT) fail_timeout("no credit came back to the source");
      waited++;
      @(posedge clkrst_core_clk);
      #1;
    end
    expect_packet(pkt);
    in_valid  = 1'b1;
    in_packet = pkt;
    sent_cnt++;
    if (credits() < min_credits) min_credits = credits();
    @(posedge clkrst_core_clk);
    #1;
    in_valid = 1'b0;
  endtask

  // Every credit comes back before its packet reaches writeback
  task automatic drain_pipe();
    int waited;
    waited = 0;
    while (exp_we_q.size() != 0) begin
      if (waited == WAIT_LIMIT) fail_timeout("pipeline did not drain");
      waited++;
      @(posedge clkrst_core_clk);
      #1;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = err_cnt;
  endtask

  task automatic end_test();
    drain_pipe();
    test_cnt++;
    if (err_cnt != test_errs) fail_cnt++;
    $display("%-16s %s, %0d errors", test_name, (err_cnt == test_errs) ? "ok" : "FAILED",
             err_cnt - test_errs);
  endtask

  task automatic check_writeback();
    lane_mask_t               we;
    reg_num_t [NUM_LANES-1:0] nums;
    word_t [NUM_LANES-1:0]    data;
    assert (exp_we_q.size() != 0) else begin
      $display("Unexpected writeback in %s with no packet outstanding", test_name);
      err_cnt++;
    end
    if (exp_we_q.size() != 0) begin
      we   = exp_we_q.pop_front();
      nums = exp_num_q.pop_front();
      data = exp_data_q.pop_front();
      assert (wb_we == we) else report_value("write mask", 32'(we), 32'(wb_we));
      for (int i = 0; i < NUM_LANES; i++) begin
        if (we[i]) begin
          assert (wb_rd_num[i] == nums[i])
            else report_value($sformatf("lane %0d rd", i), 32'(nums[i]), 32'(wb_rd_num[i]));
          assert (wb_rd_data[i] == data[i])
            else report_value($sformatf("lane %0d data", i), data[i], wb_rd_data[i]);
        end
      end
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clkrst_core_clk) begin
    if (clkrst_core_rst_n && credit_return) ret_cnt++;
    if (clkrst_core_rst_n && wb_valid) begin
      wb_cnt++;
      check_writeback();
    end
  end

  initial begin
    wait (timed_out);
    $display("Test failed");
    $finish;
  end

  initial begin
    packet_t pkt;
    int      sent0;
    int      ret0;
    int      wb0;
    lcg_state         = 32'h420bb834;
    in_valid          = 1'b0;
    in_packet         = '0;
    clkrst_core_rst_n = 1'b0;
    for (int r = 0; r < NUM_REGS; r++) ref_regs[r] = '0;
    repeat (2) @(posedge clkrst_core_clk);
    #1;
    clkrst_core_rst_n = 1'b1;

    begin_test("reset_idle");
    repeat (10) @(posedge clkrst_core_clk);
    #1;
    assert (ret_cnt == 0) else report_value("credit returns", 0, ret_cnt);
    assert (wb_cnt == 0) else report_value("writebacks", 0, wb_cnt);
    end_test();

    begin_test("alu_ops");
    for (int k = 0; k < 48; k++) begin
      pkt = random_packet(NUM_REGS);
      pkt[0][31:28] = 4'(k % 16);  // Every opcode, valid or not
      send_packet(pkt);
    end
    end_test();

    begin_test("lane_semantics");
    send_packet({make_inst(OP_NOP, 5'd0, 5'd0, 5'd0, 13'd0), make_inst(OP_NOP, 5'd0, 5'd0,
                 5'd0, 13'd0), make_inst(OP_ADDI, 5'd6, 5'd0, 5'd0, 13'h1ff0),
                 make_inst(OP_ADDI, 5'd5, 5'd0, 5'd0, 13'd100)});
    // r5 rewritten by lane 0, read by the others; r7 shared by lanes 2 and 3
    send_packet({make_inst(OP_XOR, 5'd7, 5'd5, 5'd6, 13'd0), make_inst(OP_SUB, 5'd7, 5'd5,
                 5'd6, 13'd0), make_inst(OP_ADD, 5'd8, 5'd5, 5'd6, 13'd0),
                 make_inst(OP_ADDI, 5'd5, 5'd5, 5'd0, 13'd1)});
    send_packet({make_inst(4'hc, 5'd9, 5'd7, 5'd0, 13'd0), make_inst(OP_ADD, 5'd0, 5'd7,
                 5'd8, 13'd0), make_inst(OP_ADD, 5'd10, 5'd8, 5'd0, 13'd0),
                 make_inst(OP_OR, 5'd9, 5'd7, 5'd5, 13'd0)});
    end_test();

    begin_test("dependent");
    for (int k = 0; k < 40; k++) send_packet(random_packet(4));
    end_test();

    begin_test("credits");
    sent0       = sent_cnt;
    ret0        = ret_cnt;
    min_credits = QUEUE_DEPTH;
    for (int k = 0; k < 3 * QUEUE_DEPTH; k++) begin
      send_packet({NUM_LANES{make_inst(OP_ADDI, 5'd1, 5'd1, 5'd0, 13'd3)}});  // Chained on r1
    end
    drain_pipe();
    assert (min_credits == 0) else report_value("lowest credit count", 0, min_credits);
    assert (ret_cnt - ret0 == sent_cnt - sent0)
      else report_value("credit returns", sent_cnt - sent0, ret_cnt - ret0);
    end_test();

    begin_test("ordering");
    sent0 = sent_cnt;
    wb0   = wb_cnt;
    for (int k = 0; k < 200; k++) send_packet(random_packet(8));
    drain_pipe();
    assert (wb_cnt - wb0 == sent_cnt - sent0)
      else report_value("writeback count", sent_cnt - sent0, wb_cnt - wb0);
    end_test();

    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
hdl/core_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/packet_queue.sv
hdl/issue_ctrl.sv
hdl/lane_decode.sv
hdl/reg_file.sv
hdl/lane_alu.sv
hdl/mcpu_core.sv
test/mcpu_core_asserts.sv
test/mcpu_core_tb.sv

//--- Makefile
TOP := mcpu_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
